// File: pcm_defs.svh
/* Widths, table size and sample buffer depth for the PCM sound block */

`ifndef PCM_DEFS_SVH
`define PCM_DEFS_SVH

// Sample ROM map
`define PCM_ROM_AW   17     // Bank, ctrl bit 0, offset
`define PCM_OFS_W    14     // Offset inside one bank half

// Sample table
`define PCM_TBL_AW   5      // 8 entries of 4 bytes
`define PCM_LEN_W    16     // Sample length in bytes

// Flow control between fetch and playback
`define PCM_CREDITS  4      // Buffer depth, also initial credit count

`endif

// File: pcm_pkg.sv
/* Vector types and sequencer state encoding shared by the PCM sound blocks */

`include "pcm_defs.svh"

package pcm_pkg;

    // ROM side
    typedef logic [`PCM_ROM_AW-1:0] rom_addr_t;
    typedef logic [`PCM_OFS_W-1:0]  ofs_t;     // Wraps inside the bank half
    typedef logic [`PCM_LEN_W-1:0]  len_t;

    // Raw byte from ROM or table, unsigned PCM
    typedef logic [7:0]             byte_t;
    // Output sample, two's complement
    typedef logic signed [7:0]      sample_t;

    typedef logic [`PCM_TBL_AW-1:0] tbl_addr_t;

    // Holds 0 up to PCM_CREDITS inclusive
    typedef logic [$clog2(`PCM_CREDITS+1)-1:0] credit_t;

    // Fetch sequencer
    typedef enum logic [1:0] {
        IDLE,       // Waiting for irqn falling edge
        LOOKUP,     // Reading 4 table bytes
        FETCH,      // ROM requests under credit
        DRAIN       // Waiting for the buffer to play out
    } seq_state_t;

endpackage

// File: pcm_player.sv
/* Sample rate pacing, unsigned to signed conversion and output strobe */

`timescale 1ns/1ps

module pcm_player (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             cen_pcm_i,     // One pulse per output sample
    // Buffer read side
    input  logic             empty_i,
    input  pcm_pkg::byte_t   pop_data_i,
    output logic             pop_o,
    // Sound output
    output pcm_pkg::sample_t snd_o,
    output logic             snd_valid_o
);

    // Pop only on a rate pulse with data waiting
    assign pop_o = cen_pcm_i & ~empty_i;

    // Strobe follows the pop by one clock
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) snd_valid_o <= 1'b0;
        else       snd_valid_o <= pop_o;
    end

    // Offset binary to two's complement, 0x80 is silence
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            snd_o <= '0;
        end else if (pop_o) begin
            snd_o <= {~pop_data_i[7], pop_data_i[6:0]};
        end
        // Underrun keeps the last sample
    end

endmodule

// File: pcm_sample_fifo.sv
/* Four entry sample buffer between ROM fetch and playback, one credit per pop */

`timescale 1ns/1ps
`include "pcm_defs.svh"

module pcm_sample_fifo (
    input  logic           clk,
    input  logic           rst_i,
    // Write side, from ROM
    input  logic           push_i,
    input  pcm_pkg::byte_t push_data_i,
    // Read side, to player
    input  logic           pop_i,
    output pcm_pkg::byte_t pop_data_o,
    output logic           empty_o,
    // Credit back to the sequencer
    output logic           credit_o
);

    localparam int BUF_AW = $clog2(`PCM_CREDITS);

    pcm_pkg::byte_t    mem [0:`PCM_CREDITS-1];

    // Extra top bit tells full from empty
    logic [BUF_AW:0]   wr_ptr_q;
    logic [BUF_AW:0]   rd_ptr_q;
    logic              full;
    logic              pop_ok;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full    = (wr_ptr_q[BUF_AW] != rd_ptr_q[BUF_AW]) &&
                     (wr_ptr_q[BUF_AW-1:0] == rd_ptr_q[BUF_AW-1:0]);

    assign pop_ok   = pop_i & ~empty_o;
    assign credit_o = pop_ok;                         // One credit per sample played

    // Head of the buffer, shown without a read cycle
    assign pop_data_o = mem[rd_ptr_q[BUF_AW-1:0]];

    // Storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q[BUF_AW-1:0]] <= push_data_i;
        end
    end

    // Write pointer
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i)       wr_ptr_q <= '0;
        else if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;  // Credits keep it from overrunning
    end

    // Read pointer
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
        end else if (pop_ok) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // Sequencer must hold a credit for every push
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst_i)
        push_i |-> !full
    ) else $error("Push into full sample buffer, credit protocol broken");

endmodule

// File: pcm_sequencer.sv
/* Command capture, bank decode, table lookup and credit limited sample ROM fetch */

`timescale 1ns/1ps
`include "pcm_defs.svh"

module pcm_sequencer (
    input  logic               clk,
    input  logic               rst_i,       // Local reset, active high
    // Host command
    input  pcm_pkg::byte_t     ctrl_i,
    input  logic               irqn_i,
    // Sample table
    output pcm_pkg::tbl_addr_t tbl_addr_o,
    input  pcm_pkg::byte_t     tbl_data_i,
    // Credit return from the buffer
    input  logic               credit_i,
    // Sample ROM
    output pcm_pkg::rom_addr_t pcm_addr_o,
    output logic               pcm_cs_o,
    input  logic               pcm_ok_i,
    // Buffer write strobe, data comes straight from ROM
    output logic               push_o,
    output logic               busy_o
);

    pcm_pkg::seq_state_t state_q;

    logic                irqn_q;        // Previous irqn for edge detect
    logic                irq_fall;
    logic [2:0]          entry_q;       // Table entry, ctrl bits 7..5
    logic [1:0]          bank_q;        // Latched priority decode
    logic                half_q;        // Latched ctrl bit 0
    logic [2:0]          step_q;        // Lookup step 0..4
    pcm_pkg::ofs_t       ofs_q;
    pcm_pkg::byte_t      len_lo_q;
    pcm_pkg::len_t       len_next;
    pcm_pkg::len_t       remain_q;      // Bytes not yet returned by ROM
    pcm_pkg::credit_t    credits_q;
    logic                cs_q;
    logic                lk_done;
    logic                issue;
    logic                rom_ack;

    assign irq_fall = irqn_q & ~irqn_i;

    // Address byte n at step n, data arrives at step n+1
    assign tbl_addr_o = {entry_q, step_q[1:0]};
    assign lk_done    = (state_q == pcm_pkg::LOOKUP) && (step_q == 3'd4);
    assign len_next   = {tbl_data_i, len_lo_q};  // Length high byte is on the bus now

    assign rom_ack = cs_q & pcm_ok_i;

    // New ROM request, one outstanding at most
    always_comb begin
        issue = 1'b0;
        if (credits_q != '0) begin
            if (lk_done) begin
                issue = (len_next != '0);
            end else if (state_q == pcm_pkg::FETCH) begin
                issue = !cs_q && (remain_q != '0);  // cs low one cycle after ack
            end
        end
    end

    assign pcm_addr_o = {bank_q, half_q, ofs_q};
    assign pcm_cs_o   = cs_q;
    assign push_o     = rom_ack;        // ROM byte valid this clock
    assign busy_o     = (state_q != pcm_pkg::IDLE);

    // irqn edge detector, idle level high
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) irqn_q <= 1'b1;
        else       irqn_q <= irqn_i;
    end

    // Main FSM
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            state_q  <= pcm_pkg::IDLE;
            step_q   <= '0;
            entry_q  <= '0;
            bank_q   <= '0;
            half_q   <= 1'b0;
        end else begin
            case (state_q)
                pcm_pkg::IDLE: begin
                    if (irq_fall) begin
                        state_q <= pcm_pkg::LOOKUP;
                        step_q  <= '0;
                        entry_q <= ctrl_i[7:5];
                        half_q  <= ctrl_i[0];
                        // Highest set bit of 4..1 wins
                        casez (ctrl_i[4:1])
                            4'b1???: bank_q <= 2'd3;
                            4'b01??: bank_q <= 2'd2;
                            4'b001?: bank_q <= 2'd1;
                            default: bank_q <= 2'd0;
                        endcase
                    end
                end
                pcm_pkg::LOOKUP: begin
                    step_q <= step_q + 3'd1;
                    if (lk_done) begin
                        // Zero length plays nothing
                        state_q <= (len_next == '0) ? pcm_pkg::IDLE : pcm_pkg::FETCH;
                    end
                end
                pcm_pkg::FETCH: begin
                    if (rom_ack && remain_q == pcm_pkg::len_t'(1)) begin
                        state_q <= pcm_pkg::DRAIN;  // Last byte in the buffer
                    end
                end
                pcm_pkg::DRAIN: begin
                    // All credits back means buffer empty and played
                    if (credits_q == pcm_pkg::credit_t'(`PCM_CREDITS)) begin
                        state_q <= pcm_pkg::IDLE;
                    end
                end
                default: state_q <= pcm_pkg::IDLE;
            endcase
        end
    end

    // Table bytes into offset and length
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            ofs_q    <= '0;
            len_lo_q <= '0;
            remain_q <= '0;
        end else begin
            if (state_q == pcm_pkg::LOOKUP) begin
                case (step_q)
                    3'd1:    ofs_q[7:0] <= tbl_data_i;
                    3'd2:    ofs_q[`PCM_OFS_W-1:8] <= tbl_data_i[`PCM_OFS_W-9:0];
                    3'd3:    len_lo_q <= tbl_data_i;
                    3'd4:    remain_q <= len_next;
                    default: ;
                endcase
            end else if (rom_ack) begin
                ofs_q    <= ofs_q + 1'b1;          // Wraps in 14 bits
                remain_q <= remain_q - 1'b1;
            end
        end
    end

    // ROM chip select, held until pcm_ok_i
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i)        cs_q <= 1'b0;
        else if (issue)   cs_q <= 1'b1;
        else if (rom_ack) cs_q <= 1'b0;
    end

    // Spend on request, refund on every pop
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            credits_q <= pcm_pkg::credit_t'(`PCM_CREDITS);
        end else begin
            credits_q <= credits_q - pcm_pkg::credit_t'(issue)
                                   + pcm_pkg::credit_t'(credit_i);
        end
    end

    // Refunds never outnumber requests
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst_i)
        credits_q <= pcm_pkg::credit_t'(`PCM_CREDITS)
    ) else $error("Credit count above buffer depth");

    // Request held with a steady address until the ROM answers
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        (pcm_cs_o && !pcm_ok_i) |=> (pcm_cs_o && $stable(pcm_addr_o))
    ) else $error("ROM request dropped or address moved before pcm_ok");

endmodule

// File: pcm_sound.f
+incdir+.
pcm_pkg.sv
pcm_table_ram.sv
pcm_sequencer.sv
pcm_sample_fifo.sv
pcm_player.sv
pcm_sound.sv
tb_pcm_sound.sv

// File: pcm_sound.sv
/* Sample playback sound block top level, local reset and block instances */

`timescale 1ns/1ps

module pcm_sound (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               cen_pcm_i,     // Output sample rate
    input  logic               soft_rstn_i,
    // Host command
    input  pcm_pkg::byte_t     ctrl_i,
    input  logic               irqn_i,
    // Table programming
    input  pcm_pkg::tbl_addr_t prog_addr_i,
    input  pcm_pkg::byte_t     prog_data_i,
    input  logic               prom_we_i,
    // Sample ROM
    output pcm_pkg::rom_addr_t pcm_addr_o,
    output logic               pcm_cs_o,
    input  pcm_pkg::byte_t     pcm_data_i,
    input  logic               pcm_ok_i,
    // Sound output
    output pcm_pkg::sample_t   snd_o,
    output logic               snd_valid_o,
    output logic               busy_o
);

    logic               rst_q;          // Local reset, active high
    pcm_pkg::tbl_addr_t tbl_addr;
    pcm_pkg::byte_t     tbl_data;
    logic               push;
    logic               pop;
    pcm_pkg::byte_t     pop_data;
    logic               empty;
    logic               credit;

    // Soft reset registered, one clock late
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) rst_q <= 1'b1;
        else           rst_q <= ~soft_rstn_i;
    end

    pcm_table_ram u_table (
        .clk       ( clk         ),
        .wr_addr_i ( prog_addr_i ),
        .wr_data_i ( prog_data_i ),
        .we_i      ( prom_we_i   ),
        .rd_addr_i ( tbl_addr    ),
        .rd_data_o ( tbl_data    )
    );

    pcm_sequencer u_seq (
        .clk        ( clk        ),
        .rst_i      ( rst_q      ),
        .ctrl_i     ( ctrl_i     ),
        .irqn_i     ( irqn_i     ),
        .tbl_addr_o ( tbl_addr   ),
        .tbl_data_i ( tbl_data   ),
        .credit_i   ( credit     ),
        .pcm_addr_o ( pcm_addr_o ),
        .pcm_cs_o   ( pcm_cs_o   ),
        .pcm_ok_i   ( pcm_ok_i   ),
        .push_o     ( push       ),
        .busy_o     ( busy_o     )
    );

    // ROM data goes straight into the buffer
    pcm_sample_fifo u_fifo (
        .clk         ( clk        ),
        .rst_i       ( rst_q      ),
        .push_i      ( push       ),
        .push_data_i ( pcm_data_i ),
        .pop_i       ( pop        ),
        .pop_data_o  ( pop_data   ),
        .empty_o     ( empty      ),
        .credit_o    ( credit     )
    );

    pcm_player u_player (
        .clk         ( clk         ),
        .rst_i       ( rst_q       ),
        .cen_pcm_i   ( cen_pcm_i   ),
        .empty_i     ( empty       ),
        .pop_data_i  ( pop_data    ),
        .pop_o       ( pop         ),
        .snd_o       ( snd_o       ),
        .snd_valid_o ( snd_valid_o )
    );

endmodule

// File: pcm_table_ram.sv
/* Sample table memory, 32 bytes, loaded through the programming port */

`timescale 1ns/1ps

module pcm_table_ram (
    input  logic              clk,
    // Programming port
    input  pcm_pkg::tbl_addr_t wr_addr_i,
    input  pcm_pkg::byte_t     wr_data_i,
    input  logic              we_i,
    // Sequencer side
    input  pcm_pkg::tbl_addr_t rd_addr_i,
    output pcm_pkg::byte_t     rd_data_o
);

    // 8 entries x 4 bytes: ofs lo, ofs hi, len lo, len hi
    pcm_pkg::byte_t mem [0:(1 << $bits(pcm_pkg::tbl_addr_t))-1];

    // Write on every clock with we_i high
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Registered read, data one clock after address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// File: tb_pcm_sound.sv
/* Directed testbench for the PCM sound block with ROM model, table loader, LFSR and compare tasks */

`timescale 1ns/1ps
`include "pcm_defs.svh"

module tb_pcm_sound;

    localparam int TIMEOUT = 4000;      // Cycles per wait loop

    logic clk = 1'b0;
    logic arst_n_i, cen_pcm_i, soft_rstn_i, irqn_i, prom_we_i, pcm_ok_i;
    pcm_pkg::byte_t     ctrl_i, prog_data_i, pcm_data_i;
    pcm_pkg::tbl_addr_t prog_addr_i;
    pcm_pkg::rom_addr_t pcm_addr_o;
    pcm_pkg::sample_t   snd_o;
    logic               pcm_cs_o, snd_valid_o, busy_o;

    int errors = 0;
    int checks = 0;
    int cen_div = 8;                    // Clocks per cen_pcm_i pulse
    int cen_cnt = 0;
    int slow_extra = 0;                 // Added ROM latency
    int rom_wait = 0;
    int req_n = 0;
    bit rom_armed = 1'b0;
    logic [15:0] lfsr_q = 16'd61453;
    pcm_pkg::sample_t   got_q [$];      // Strobed samples
    pcm_pkg::rom_addr_t addr_q [$];     // ROM requests seen

    pcm_sound dut_i (.*);

    always #50 clk = ~clk;

    // Galois LFSR stepped once per output bit
    function automatic logic lfsr_step();
        logic out_b;
        out_b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out_b) lfsr_q = lfsr_q ^ 16'hB400;
        return out_b;
    endfunction

    // Priority decode of ctrl bits 4..1
    function automatic logic [1:0] bank_of(input pcm_pkg::byte_t c);
        if (c[4]) return 2'd3;
        if (c[3]) return 2'd2;
        if (c[2]) return 2'd1;
        return 2'd0;
    endfunction

    // Sample rate pulse
    always @(negedge clk) begin
        if (cen_cnt >= cen_div - 1) begin
            cen_cnt = 0;
            cen_pcm_i = 1'b1;
        end else begin
            cen_cnt++;
            cen_pcm_i = 1'b0;
        end
    end

    // Output monitor
    always @(negedge clk) begin
        if (snd_valid_o) got_q.push_back(snd_o);
    end

    // Behavioral sample ROM with byte = addr low byte ^ 0x5A
    always @(negedge clk) begin
        if (pcm_ok_i) begin
            pcm_ok_i = 1'b0;            // Ack taken at last posedge
            rom_armed = 1'b0;
        end else if (!pcm_cs_o) begin
            rom_armed = 1'b0;           // Request gone after a soft reset
        end else begin
            if (!rom_armed) begin
                rom_armed = 1'b1;
                addr_q.push_back(pcm_addr_o);
                req_n++;
                if (req_n - got_q.size() > `PCM_CREDITS) begin
                    errors++;
                    $display("More ROM requests outstanding than buffer credits");
                end
                rom_wait = slow_extra + int'(lfsr_step());
                rom_wait = rom_wait + 2 * int'(lfsr_step());  // 0..3 cycles
            end
            if (rom_wait == 0) begin
                pcm_data_i = pcm_addr_o[7:0] ^ 8'h5A;
                pcm_ok_i = 1'b1;
            end else begin
                rom_wait--;
            end
        end
    end

    task automatic compare_sample(input string name, input pcm_pkg::sample_t exp,
                                  input pcm_pkg::sample_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_addr(input string name, input pcm_pkg::rom_addr_t exp,
                                input pcm_pkg::rom_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic wait_idle(input string name);
        int n;
        n = 0;
        while (busy_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy_o) begin
            errors++;
            $display("Timeout in %s: busy_o never fell", name);
        end
    endtask

    task automatic wait_strobes(input string name, input int count);
        int n;
        n = 0;
        while (got_q.size() < count && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (got_q.size() < count) begin
            errors++;
            $display("Timeout in %s: too few output samples", name);
        end
    endtask

    // Entry layout is ofs lo, ofs hi, len lo, len hi
    task automatic load_entry(input logic [2:0] idx, input pcm_pkg::ofs_t ofs,
                              input pcm_pkg::len_t len);
        pcm_pkg::byte_t bytes [4];
        bytes[0] = ofs[7:0];
        bytes[1] = {2'b00, ofs[13:8]};
        bytes[2] = len[7:0];
        bytes[3] = len[15:8];
        for (int i = 0; i < 4; i++) begin
            prog_addr_i = {idx, 2'(i)};
            prog_data_i = bytes[i];
            prom_we_i = 1'b1;
            @(negedge clk);
        end
        prom_we_i = 1'b0;
    endtask

    task automatic send_cmd(input pcm_pkg::byte_t ctrl);
        ctrl_i = ctrl;
        irqn_i = 1'b0;                  // Falling edge starts a command
        @(negedge clk);
        irqn_i = 1'b1;
        @(negedge clk);
    endtask

    task automatic start_run(input pcm_pkg::byte_t ctrl);
        got_q.delete();
        addr_q.delete();
        req_n = 0;
        send_cmd(ctrl);
    endtask

    // Expected address and sample list built from the ROM map
    task automatic finish_run(input string name, input pcm_pkg::byte_t ctrl,
                              input pcm_pkg::ofs_t ofs, input int len);
        pcm_pkg::rom_addr_t exp_addr;
        pcm_pkg::byte_t     rom_b;
        wait_idle(name);
        compare_count({name, " samples"}, len, got_q.size());
        compare_count({name, " requests"}, len, addr_q.size());
        for (int i = 0; i < len; i++) begin
            exp_addr = {bank_of(ctrl), ctrl[0], pcm_pkg::ofs_t'(ofs + i)};
            rom_b = exp_addr[7:0] ^ 8'h5A;
            if (i < addr_q.size()) compare_addr(name, exp_addr, addr_q[i]);
            if (i < got_q.size()) begin
                compare_sample(name, pcm_pkg::sample_t'(int'(rom_b) - 128), got_q[i]);
            end
        end
    endtask

    task automatic test_basic();
        compare_flag("reset cs", 1'b0, pcm_cs_o);
        compare_flag("reset busy", 1'b0, busy_o);
        compare_flag("reset strobe", 1'b0, snd_valid_o);
        compare_sample("reset snd", '0, snd_o);
        load_entry(3'd0, 14'h0040, 16'd6);
        start_run(8'h00);
        compare_flag("basic busy", 1'b1, busy_o);
        finish_run("basic", 8'h00, 14'h0040, 6);
    endtask

    task automatic test_bank_decode();
        logic [3:0] pats [8] = '{4'b0000, 4'b0001, 4'b0010, 4'b0100,
                                 4'b1000, 4'b0110, 4'b1011, 4'b0011};
        pcm_pkg::byte_t ctrl;
        load_entry(3'd1, 14'h1234, 16'd2);
        foreach (pats[p]) begin
            for (int b = 0; b < 2; b++) begin
                ctrl = {3'd1, pats[p], b[0]};
                start_run(ctrl);
                finish_run("bank decode", ctrl, 14'h1234, 2);
            end
        end
    endtask

    task automatic test_offset_wrap();
        load_entry(3'd2, 14'h3FFE, 16'd4);
        start_run({3'd2, 4'b0100, 1'b1});       // Bank 2 upper half
        finish_run("offset wrap", {3'd2, 4'b0100, 1'b1}, 14'h3FFE, 4);
    endtask

    task automatic test_back_pressure();
        load_entry(3'd3, 14'h2000, 16'd20);
        slow_extra = 5;                         // Slow ROM against fast playback
        cen_div = 2;
        start_run({3'd3, 4'b1000, 1'b1});
        finish_run("slow rom", {3'd3, 4'b1000, 1'b1}, 14'h2000, 20);
        slow_extra = 0;                         // Fast ROM fills the buffer
        cen_div = 12;
        start_run({3'd3, 4'b1000, 1'b1});
        finish_run("full buffer", {3'd3, 4'b1000, 1'b1}, 14'h2000, 20);
        cen_div = 8;
    endtask

    task automatic test_zero_and_busy();
        load_entry(3'd5, 14'h0000, 16'd0);
        start_run({3'd5, 4'b0000, 1'b0});
        compare_flag("zero busy", 1'b1, busy_o);  // Lookup still runs
        wait_idle("zero length");
        repeat (10) @(negedge clk);
        compare_count("zero samples", 0, got_q.size());
        compare_count("zero requests", 0, addr_q.size());
        start_run(8'h00);
        wait_strobes("ignored irq", 2);
        send_cmd({3'd3, 4'b1000, 1'b1});        // Must be dropped while busy
        finish_run("ignored irq", 8'h00, 14'h0040, 6);
    endtask

    task automatic test_soft_reset();
        load_entry(3'd4, 14'h0100, 16'd30);
        start_run({3'd4, 4'b0010, 1'b0});
        wait_strobes("soft reset", 3);
        soft_rstn_i = 1'b0;
        @(negedge clk);
        soft_rstn_i = 1'b1;
        @(negedge clk);                         // Registered reset has hit
        compare_flag("soft reset busy", 1'b0, busy_o);
        compare_flag("soft reset cs", 1'b0, pcm_cs_o);
        got_q.delete();
        repeat (20) @(negedge clk);
        compare_count("strobes after abort", 0, got_q.size());
        start_run(8'h00);
        finish_run("after soft reset", 8'h00, 14'h0040, 6);
    endtask

    initial begin
        arst_n_i = 1'b0;
        soft_rstn_i = 1'b1;
        cen_pcm_i = 1'b0;
        ctrl_i = '0;
        irqn_i = 1'b1;
        prog_addr_i = '0;
        prog_data_i = '0;
        prom_we_i = 1'b0;
        pcm_ok_i = 1'b0;
        pcm_data_i = '0;
        repeat (5) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        test_basic();
        test_bank_decode();
        test_offset_wrap();
        test_back_pressure();
        test_zero_and_busy();
        test_soft_reset();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
